// File: core_pkg.sv
package core_pkg;

    // Datapath widths
    localparam int XLEN        = 32;
    localparam int BUNDLE_W    = 2 * XLEN;
    localparam int REG_IDX_W   = 5;
    localparam int NUM_REGS    = 32;

    // Default bundle address width that the top level overrides
    localparam int IMEM_AW_DEF = 8;

    // One data word or one slot instruction
    typedef logic [XLEN-1:0] word_t;

    // Two slots with slot 0 in the low half
    typedef logic [BUNDLE_W-1:0] bundle_t;

    // Bundle address counted in bundles and not bytes
    typedef logic [IMEM_AW_DEF-1:0] pc_t;

    // Architectural register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 for ALU operations
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // funct7
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_ADDI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE
    } branch_kind_t;

endpackage

// File: fetch_unit.sv
module fetch_unit
    import core_pkg::*;
#(
    parameter int IMEM_AW = IMEM_AW_DEF
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    run,
    input  logic    load_we,
    input  pc_t     load_addr,
    input  bundle_t load_bundle,
    input  logic    branch_taken,
    input  pc_t     branch_target,
    output bundle_t if_bundle,
    output pc_t     if_pc,
    output logic    if_valid
);

    bundle_t imem [2**IMEM_AW];
    pc_t     pc;

    // Load port written from outside while the core is halted
    always_ff @(posedge clk) begin
        if (load_we) begin
            imem[load_addr[IMEM_AW-1:0]] <= load_bundle;
        end
    end

    // A taken branch in decode wins over sequential fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (run) begin
            pc <= pc + pc_t'(1);
        end
    end

    // Synchronous read that reaches decode one clock later
    always_ff @(posedge clk) begin
        if_bundle <= imem[pc[IMEM_AW-1:0]];
        if_pc     <= pc;
    end

    // Squash the bundle fetched under a taken branch
    always_ff @(posedge clk) begin
        if (reset) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= run && !branch_taken;
        end
    end

endmodule

// File: bundle_decode.sv
module bundle_decode
    import core_pkg::*;
    import isa_pkg::*;
#(
    parameter int IMEM_AW = IMEM_AW_DEF
) (
    input  logic     clk,
    input  logic     reset,
    input  bundle_t  if_bundle,
    input  pc_t      if_pc,
    input  logic     if_valid,
    input  word_t    alu_fwd_0,
    input  word_t    alu_fwd_1,
    input  word_t    ex_res_0,
    input  word_t    ex_res_1,
    input  reg_idx_t ex_rd_0,
    input  reg_idx_t ex_rd_1,
    input  logic     ex_we_0,
    input  logic     ex_we_1,
    input  logic     ex_valid,
    input  word_t    wb_data_0,
    input  word_t    wb_data_1,
    input  reg_idx_t wb_rd_0,
    input  reg_idx_t wb_rd_1,
    input  logic     wb_we_0,
    input  logic     wb_we_1,
    output logic     dec_valid,
    output pc_t      dec_pc,
    output word_t    dec_op1_0,
    output word_t    dec_op1_1,
    output word_t    dec_op2_0,
    output word_t    dec_op2_1,
    output alu_op_t  dec_alu_op_0,
    output alu_op_t  dec_alu_op_1,
    output reg_idx_t dec_rd_0,
    output reg_idx_t dec_rd_1,
    output logic     dec_we_0,
    output logic     dec_we_1,
    output logic     branch_taken,
    output pc_t      branch_target
);

    word_t        rf [NUM_REGS];
    word_t        ins_0, ins_1;
    word_t        imm_0, imm_1;
    word_t        br_off;
    word_t        src1_0, src2_0, src1_1, src2_1;
    alu_op_t      op_0, op_1;
    branch_kind_t br_kind;
    logic         br_cond;

    function automatic alu_op_t decode_alu(word_t ins);
        alu_op_t op;
        op = ALU_NOP;
        if (ins[6:0] == OP_REG) begin
            case ({ins[31:25], ins[14:12]})
                {F7_BASE, F3_ADD_SUB}: op = ALU_ADD;
                {F7_SUB,  F3_ADD_SUB}: op = ALU_SUB;
                {F7_BASE, F3_AND}:     op = ALU_AND;
                {F7_BASE, F3_OR}:      op = ALU_OR;
                {F7_BASE, F3_XOR}:     op = ALU_XOR;
                {F7_BASE, F3_SLT}:     op = ALU_SLT;
                {F7_BASE, F3_SLL}:     op = ALU_SLL;
                {F7_BASE, F3_SRL}:     op = ALU_SRL;
                default:               op = ALU_NOP;
            endcase
        end else if (ins[6:0] == OP_IMM && ins[14:12] == F3_ADD_SUB) begin
            op = ALU_ADDI;
        end
        return op;
    endfunction

    function automatic branch_kind_t decode_branch(word_t ins);
        branch_kind_t kind;
        kind = BR_NONE;
        if (ins[6:0] == OP_BRANCH) begin
            case (ins[14:12])
                F3_BEQ:  kind = BR_EQ;
                F3_BNE:  kind = BR_NE;
                F3_BLT:  kind = BR_LT;
                F3_BGE:  kind = BR_GE;
                default: kind = BR_NONE;
            endcase
        end
        return kind;
    endfunction

    // Youngest producer first with lane 1 ahead of lane 0 at each stage
    function automatic word_t fwd_read(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (dec_we_1 && dec_rd_1 == idx) begin
            return alu_fwd_1;
        end else if (dec_we_0 && dec_rd_0 == idx) begin
            return alu_fwd_0;
        end else if (ex_valid && ex_we_1 && ex_rd_1 == idx) begin
            return ex_res_1;
        end else if (ex_valid && ex_we_0 && ex_rd_0 == idx) begin
            return ex_res_0;
        end else if (wb_we_1 && wb_rd_1 == idx) begin
            return wb_data_1;
        end else if (wb_we_0 && wb_rd_0 == idx) begin
            return wb_data_0;
        end
        return rf[idx];
    endfunction

    // Lane 1 written last so it wins on equal rd
    always_ff @(posedge clk) begin
        if (wb_we_0) begin
            rf[wb_rd_0] <= wb_data_0;
        end
        if (wb_we_1) begin
            rf[wb_rd_1] <= wb_data_1;
        end
    end

    assign ins_0 = if_bundle[31:0];
    assign ins_1 = if_bundle[63:32];
    assign imm_0 = {{20{ins_0[31]}}, ins_0[31:20]};
    assign imm_1 = {{20{ins_1[31]}}, ins_1[31:20]};

    // B-type immediate bits [12:1] give the offset in bundles
    assign br_off = {{20{ins_0[31]}}, ins_0[31], ins_0[7], ins_0[30:25], ins_0[11:8]};

    always_comb begin
        src1_0  = fwd_read(ins_0[19:15]);
        src2_0  = fwd_read(ins_0[24:20]);
        src1_1  = fwd_read(ins_1[19:15]);
        src2_1  = fwd_read(ins_1[24:20]);
        op_0    = decode_alu(ins_0);
        op_1    = decode_alu(ins_1);
        br_kind = decode_branch(ins_0);
        case (br_kind)
            BR_EQ:   br_cond = (src1_0 == src2_0);
            BR_NE:   br_cond = (src1_0 != src2_0);
            BR_LT:   br_cond = ($signed(src1_0) < $signed(src2_0));
            BR_GE:   br_cond = ($signed(src1_0) >= $signed(src2_0));
            default: br_cond = 1'b0;
        endcase
    end

    assign branch_taken  = if_valid && br_cond;
    assign branch_target = if_pc + pc_t'(br_off[IMEM_AW-1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_we_0  <= 1'b0;
            dec_we_1  <= 1'b0;
        end else begin
            dec_valid <= if_valid;
            dec_we_0  <= if_valid && (op_0 != ALU_NOP);
            dec_we_1  <= if_valid && (op_1 != ALU_NOP);
        end
    end

    always_ff @(posedge clk) begin
        dec_pc       <= if_pc;
        dec_op1_0    <= src1_0;
        dec_op1_1    <= src1_1;
        dec_op2_0    <= (op_0 == ALU_ADDI) ? imm_0 : src2_0;
        dec_op2_1    <= (op_1 == ALU_ADDI) ? imm_1 : src2_1;
        dec_alu_op_0 <= op_0;
        dec_alu_op_1 <= op_1;
        dec_rd_0     <= ins_0[11:7];
        dec_rd_1     <= ins_1[11:7];
    end

endmodule

// File: alu_lane.sv
module alu_lane
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     dec_valid,
    input  word_t    dec_op1,
    input  word_t    dec_op2,
    input  alu_op_t  dec_alu_op,
    input  reg_idx_t dec_rd,
    input  logic     dec_we,
    output word_t    alu_fwd,
    output word_t    ex_res,
    output reg_idx_t ex_rd,
    output logic     ex_we,
    output logic     ex_valid
);

    logic [4:0] shamt;

    assign shamt = dec_op2[4:0];

    // Combinational result that is also the youngest forwarding source
    always_comb begin
        case (dec_alu_op)
            ALU_ADD,
            ALU_ADDI: alu_fwd = dec_op1 + dec_op2;
            ALU_SUB:  alu_fwd = dec_op1 - dec_op2;
            ALU_AND:  alu_fwd = dec_op1 & dec_op2;
            ALU_OR:   alu_fwd = dec_op1 | dec_op2;
            ALU_XOR:  alu_fwd = dec_op1 ^ dec_op2;
            ALU_SLT:  alu_fwd = word_t'($signed(dec_op1) < $signed(dec_op2));
            ALU_SLL:  alu_fwd = dec_op1 << shamt;
            ALU_SRL:  alu_fwd = dec_op1 >> shamt;
            default:  alu_fwd = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
            ex_we    <= dec_valid && dec_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_res <= alu_fwd;
        ex_rd  <= dec_rd;
    end

endmodule

// File: result_writeback.sv
module result_writeback
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     ex_valid,
    input  pc_t      ex_pc,
    input  word_t    ex_res_0,
    input  word_t    ex_res_1,
    input  reg_idx_t ex_rd_0,
    input  reg_idx_t ex_rd_1,
    input  logic     ex_we_0,
    input  logic     ex_we_1,
    output logic     retire_valid,
    output pc_t      retire_pc,
    output logic     wb_we_0,
    output logic     wb_we_1,
    output reg_idx_t wb_rd_0,
    output reg_idx_t wb_rd_1,
    output word_t    wb_data_0,
    output word_t    wb_data_1
);

    // Register 0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            wb_we_0      <= 1'b0;
            wb_we_1      <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
            wb_we_0      <= ex_valid && ex_we_0 && (ex_rd_0 != '0);
            wb_we_1      <= ex_valid && ex_we_1 && (ex_rd_1 != '0);
        end
    end

    // Same registers feed the register file and the retire ports
    always_ff @(posedge clk) begin
        retire_pc <= ex_pc;
        wb_rd_0   <= ex_rd_0;
        wb_rd_1   <= ex_rd_1;
        wb_data_0 <= ex_res_0;
        wb_data_1 <= ex_res_1;
    end

endmodule

// File: vliw_core.sv
module vliw_core
    import core_pkg::*;
    import isa_pkg::*;
#(
    parameter int IMEM_AW = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     run,
    input  logic     load_we,
    input  pc_t      load_addr,
    input  bundle_t  load_bundle,
    output logic     retire_valid,
    output pc_t      retire_pc,
    output logic     wb_we_0,
    output reg_idx_t wb_rd_0,
    output word_t    wb_data_0,
    output logic     wb_we_1,
    output reg_idx_t wb_rd_1,
    output word_t    wb_data_1
);

    bundle_t  if_bundle;
    pc_t      if_pc;
    logic     if_valid;
    logic     branch_taken;
    pc_t      branch_target;
    logic     dec_valid;
    pc_t      dec_pc;
    word_t    dec_op1_0, dec_op1_1, dec_op2_0, dec_op2_1;
    alu_op_t  dec_alu_op_0, dec_alu_op_1;
    reg_idx_t dec_rd_0, dec_rd_1;
    logic     dec_we_0, dec_we_1;
    word_t    alu_fwd_0, alu_fwd_1;
    word_t    ex_res_0, ex_res_1;
    reg_idx_t ex_rd_0, ex_rd_1;
    logic     ex_we_0, ex_we_1;
    logic     ex_valid;
    pc_t      ex_pc;

    fetch_unit #(.IMEM_AW(IMEM_AW)) fetch_unit_i (
        .clk, .reset, .run, .load_we, .load_addr, .load_bundle,
        .branch_taken, .branch_target, .if_bundle, .if_pc, .if_valid
    );

    bundle_decode #(.IMEM_AW(IMEM_AW)) bundle_decode_i (
        .clk, .reset, .if_bundle, .if_pc, .if_valid,
        .alu_fwd_0, .alu_fwd_1, .ex_res_0, .ex_res_1, .ex_rd_0, .ex_rd_1,
        .ex_we_0, .ex_we_1, .ex_valid,
        .wb_data_0, .wb_data_1, .wb_rd_0, .wb_rd_1, .wb_we_0, .wb_we_1,
        .dec_valid, .dec_pc, .dec_op1_0, .dec_op1_1, .dec_op2_0, .dec_op2_1,
        .dec_alu_op_0, .dec_alu_op_1, .dec_rd_0, .dec_rd_1, .dec_we_0, .dec_we_1,
        .branch_taken, .branch_target
    );

    alu_lane alu_lane_0 (
        .clk, .reset, .dec_valid,
        .dec_op1(dec_op1_0), .dec_op2(dec_op2_0), .dec_alu_op(dec_alu_op_0),
        .dec_rd(dec_rd_0), .dec_we(dec_we_0),
        .alu_fwd(alu_fwd_0), .ex_res(ex_res_0), .ex_rd(ex_rd_0), .ex_we(ex_we_0),
        .ex_valid(ex_valid)
    );

    // Lane 1 shares the execute valid bit of lane 0
    alu_lane alu_lane_1 (
        .clk, .reset, .dec_valid,
        .dec_op1(dec_op1_1), .dec_op2(dec_op2_1), .dec_alu_op(dec_alu_op_1),
        .dec_rd(dec_rd_1), .dec_we(dec_we_1),
        .alu_fwd(alu_fwd_1), .ex_res(ex_res_1), .ex_rd(ex_rd_1), .ex_we(ex_we_1),
        .ex_valid()
    );

    // Bundle pc rides alongside the lane 0 execute registers
    always_ff @(posedge clk) begin
        ex_pc <= dec_pc;
    end

    result_writeback result_writeback_i (
        .clk, .reset, .ex_valid, .ex_pc,
        .ex_res_0, .ex_res_1, .ex_rd_0, .ex_rd_1, .ex_we_0, .ex_we_1,
        .retire_valid, .retire_pc,
        .wb_we_0, .wb_we_1, .wb_rd_0, .wb_rd_1, .wb_data_0, .wb_data_1
    );

endmodule

// File: tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end
endmodule

// File: tb_vliw_core.sv
module tb_vliw_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk, reset, run, load_we, retire_valid, wb_we_0, wb_we_1;
    logic [7:0] load_addr, retire_pc;
    logic [63:0] load_bundle;
    logic [4:0] wb_rd_0, wb_rd_1;
    logic [31:0] wb_data_0, wb_data_1;

    logic [63:0] prog [256];
    logic [31:0] regs [32];
    logic [7:0] exp_pc [$];
    logic [75:0] exp_wr [$];
    integer seed, prog_len, cycles, i, d, p;
    logic started;

    // Branch cases packed as {rs2, rs1, funct3}
    // Four taken cases come first and four not taken follow
    logic [12:0] d_list [8] = '{{5'd6, 5'd6, 3'd0}, {5'd7, 5'd6, 3'd1}, {5'd7, 5'd6, 3'd4},
                                {5'd6, 5'd7, 3'd5}, {5'd7, 5'd6, 3'd0}, {5'd7, 5'd7, 3'd1},
                                {5'd6, 5'd7, 3'd4}, {5'd7, 5'd6, 3'd5}};

    tb_clock clock_gen (.clk, .reset);
    vliw_core #(.IMEM_AW(8)) vliw_core_i (.*);

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                               logic [11:0] off);
        logic [12:0] im;
        im = {off, 1'b0};
        return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], 7'h63};
    endfunction

    // Op index 0 to 8 selects ADD SUB AND OR XOR SLT SLL SRL ADDI
    function automatic logic [31:0] enc_op(int k, logic [4:0] rd, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [11:0] imm);
        logic [2:0] f3_tab [8];
        f3_tab = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5};
        if (k == 8) begin
            return enc_addi(rd, rs1, imm);
        end
        return enc_r(k == 1 ? 7'h20 : 7'h00, f3_tab[k], rd, rs1, rs2);
    endfunction

    // Registers x1 to x15 hold the random setup values
    function automatic logic [4:0] random_src_reg();
        return 5'(1 + $unsigned($random(seed)) % 15);
    endfunction

    // Reference result of one ALU slot on pre-bundle register values
    function automatic logic [31:0] slot_value(logic [31:0] ins, output logic we);
        logic [31:0] a, b, imm;
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        imm = {{20{ins[31]}}, ins[31:20]};
        we = (ins[11:7] != 0);
        if (ins[6:0] == 7'h13 && ins[14:12] == 0) begin
            return a + imm;
        end
        if (ins[6:0] != 7'h33) begin
            we = 1'b0;
        end
        case (ins[14:12])
            3'd0: return ins[30] ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a | b;
            3'd7: return a & b;
            default: we = 1'b0;
        endcase
        return 32'b0;
    endfunction

    task automatic add_bundle(logic [31:0] s0, logic [31:0] s1);
        prog[prog_len] = {s1, s0};
        prog_len = prog_len + 1;
    endtask

    task automatic run_model();
        logic [7:0] pc;
        logic [31:0] s0, s1, v0, v1, a, b;
        logic [12:0] boff;
        logic we0, we1, taken;
        integer steps;
        pc = 0;
        steps = 0;
        foreach (regs[r]) begin
            regs[r] = 0;
        end
        while (pc != prog_len[7:0] && steps < 1000) begin
            s0 = prog[pc][31:0];
            s1 = prog[pc][63:32];
            a = regs[s0[19:15]];
            b = regs[s0[24:20]];
            v0 = slot_value(s0, we0);
            v1 = slot_value(s1, we1);
            taken = 1'b0;
            if (s0[6:0] == 7'h63) begin
                case (s0[14:12])
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;
                endcase
            end
            exp_pc.push_back(pc);
            exp_wr.push_back({we0, s0[11:7], v0, we1, s1[11:7], v1});
            if (we0) regs[s0[11:7]] = v0;
            if (we1) regs[s1[11:7]] = v1;
            // B-type offset counted in bundles from bit 1 up
            boff = {s0[31], s0[7], s0[30:25], s0[11:8], 1'b0};
            pc = taken ? pc + boff[8:1] : pc + 8'd1;
            steps = steps + 1;
        end
    endtask

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    always @(negedge clk) begin
        logic [75:0] w;
        if (!reset && !started) begin
            assert (!retire_valid && !wb_we_0 && !wb_we_1) else begin
                $display("FAIL retire_valid/wb_we before run: %h %h %h",
                         retire_valid, wb_we_0, wb_we_1);
                stop_with_failure();
            end
        end
        if (!reset && retire_valid && exp_pc.size() > 0) begin
            w = exp_wr.pop_front();
            assert (retire_pc == exp_pc[0]) else begin
                $display("FAIL retire_pc got %h expected %h", retire_pc, exp_pc[0]);
                stop_with_failure();
            end
            void'(exp_pc.pop_front());
            assert (wb_we_0 == w[75] && wb_we_1 == w[37]) else begin
                $display("FAIL wb_we_0/wb_we_1 got %h %h expected %h %h",
                         wb_we_0, wb_we_1, w[75], w[37]);
                stop_with_failure();
            end
            assert (!w[75] || (wb_rd_0 == w[74:70] && wb_data_0 == w[69:38])) else begin
                $display("FAIL wb_rd_0/wb_data_0 got %h %h expected %h %h",
                         wb_rd_0, wb_data_0, w[74:70], w[69:38]);
                stop_with_failure();
            end
            assert (!w[37] || (wb_rd_1 == w[36:32] && wb_data_1 == w[31:0])) else begin
                $display("FAIL wb_rd_1/wb_data_1 got %h %h expected %h %h",
                         wb_rd_1, wb_data_1, w[36:32], w[31:0]);
                stop_with_failure();
            end
        end
    end

    initial begin
        run = 0;
        load_we = 0;
        load_addr = 0;
        load_bundle = 0;
        started = 0;
        seed = 42371;
        prog_len = 0;
        // Unused space holds writes to x0 tagged with their address
        for (i = 0; i < 256; i++) begin
            prog[i] = {enc_addi(0, 0, 12'(i) ^ 12'h5a5), enc_addi(0, 0, 12'(i))};
        end
        for (i = 1; i < 31; i += 2) begin
            add_bundle(enc_addi(i, 0, 12'($random(seed))),
                       enc_addi(i + 1, 0, 12'($random(seed))));
        end
        add_bundle(enc_addi(31, 0, 12'($random(seed))), enc_addi(0, 0, 0));
        for (i = 0; i < 27; i++) begin
            add_bundle(enc_op((2 * i) % 9, 16 + i % 8, random_src_reg(), random_src_reg(),
                              12'($random(seed))),
                       enc_op((2 * i + 1) % 9, 24 + i % 8, random_src_reg(), random_src_reg(),
                              12'($random(seed))));
        end
        // Producer in slot p and consumers in both slots at distance d
        for (d = 1; d <= 3; d++) begin
            for (p = 0; p < 2; p++) begin
                if (p == 0) begin
                    add_bundle(enc_addi(10, 1, 12'($random(seed))), enc_addi(0, 0, 0));
                end else begin
                    add_bundle(enc_addi(0, 0, 0), enc_addi(10, 2, 12'($random(seed))));
                end
                for (i = 1; i < d; i++) begin
                    add_bundle(enc_addi(0, 0, 1), enc_addi(0, 0, 2));
                end
                add_bundle(enc_r(0, 0, 11, 10, 3), enc_r(7'h20, 0, 12, 4, 10));
            end
        end
        add_bundle(enc_addi(20, 0, 111), enc_addi(20, 0, 222));
        add_bundle(enc_r(0, 0, 21, 20, 0), enc_addi(0, 3, 5));
        add_bundle(enc_r(0, 6, 22, 0, 1), enc_r(0, 0, 23, 0, 0));
        add_bundle(enc_addi(6, 0, -12'sd5), enc_addi(7, 0, 3));
        foreach (d_list[k]) begin
            add_bundle(enc_branch(d_list[k][2:0], d_list[k][7:3], d_list[k][12:8], 2),
                       enc_addi(24, 24, 1));
            add_bundle(enc_addi(25, 25, 12'h7ff), enc_addi(0, 0, 0));
        end
        add_bundle(enc_addi(8, 0, 0), enc_addi(9, 0, 5));
        add_bundle(enc_addi(8, 8, 1), enc_addi(26, 26, 3));
        add_bundle(enc_branch(1, 8, 9, -12'sd1), enc_addi(27, 27, 1));
        add_bundle(enc_r(0, 6, 28, 26, 0), enc_r(0, 6, 29, 8, 27));
        run_model();
        cycles = 0;
        while (reset) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Timed out waiting for reset to be released");
                stop_with_failure();
            end
        end
        for (i = 0; i < 256; i++) begin
            @(posedge clk);
            load_we     <= 1;
            load_addr   <= 8'(i);
            load_bundle <= prog[i];
        end
        @(posedge clk);
        load_we <= 0;
        repeat (3) @(posedge clk);
        run <= 1;
        started = 1;
        cycles = 0;
        while (1) begin
            @(negedge clk);
            if (retire_valid) break;
            cycles++;
            if (cycles > 20) begin
                $display("Timed out waiting for the first bundle to retire");
                stop_with_failure();
            end
        end
        assert (cycles == 4) else begin
            $display("FAIL first retire_valid latency got %h expected %h", cycles, 4);
            stop_with_failure();
        end
        cycles = 0;
        while (exp_pc.size() > 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                $display("Timed out waiting for the program to retire");
                stop_with_failure();
            end
        end
        $display("Verification passed");
        $finish;
    end
endmodule

// File: vliw_core.f
core_pkg.sv
isa_pkg.sv
fetch_unit.sv
bundle_decode.sv
alu_lane.sv
result_writeback.sv
vliw_core.sv
tb_clock.sv
tb_vliw_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f vliw_core.f \
    --top-module tb_vliw_core -Mdir obj_dir -o vsim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/vsim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Verification failed" "$SIM_LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "Verification passed" "$SIM_LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
